/* verilog/trace_pkg.sv */
//----------------------------------------------------------
// Trace monitor shared definitions
// Widths, class codes, CSR bit layout, register map, structs
//----------------------------------------------------------
package trace_pkg;

    localparam int xlen          = 32;
    localparam int count_w       = 32;
    localparam int num_classes   = 9;
    localparam int reg_addr_w    = 5;
    localparam int axil_addr_w   = 8;
    localparam int num_csr_words = 7;

    // Instruction class reported by the core at retirement
    typedef enum logic [3:0] {
        rvi_cal   = 4'd0,
        rvi_ctrl  = 4'd1,
        rvi_ls    = 4'd2,
        rvi_other = 4'd3,
        rvc_cal   = 4'd4,
        rvc_ctrl  = 4'd5,
        rvc_ls    = 4'd6,
        rvc_other = 4'd7
    } sort_sel_e;

    localparam int class_other = num_classes - 1;  // Catch-all counter

    //------------------------------------------------------
    // CSR field positions
    //------------------------------------------------------
    localparam int          mstatus_mie_off  = 3;
    localparam int          mstatus_mpie_off = 7;
    localparam int          mstatus_mpp_off  = 11;
    localparam logic [1:0]  mstatus_mpp_val  = 2'd3;  // Machine mode only
    localparam int          mie_msie_off     = 3;     // Same layout in mip
    localparam int          mie_mtie_off     = 7;
    localparam int          mie_meie_off     = 11;

    //------------------------------------------------------
    // Register map
    //------------------------------------------------------
    localparam logic [axil_addr_w-1:0] addr_ctrl        = 8'h00;
    localparam logic [axil_addr_w-1:0] addr_csr_changes = 8'h04;
    localparam logic [axil_addr_w-1:0] addr_last_pc     = 8'h08;
    localparam logic [axil_addr_w-1:0] addr_last_reg    = 8'h0C;
    localparam logic [axil_addr_w-1:0] addr_last_data   = 8'h10;
    localparam logic [axil_addr_w-1:0] addr_counts      = 8'h20;
    localparam logic [axil_addr_w-1:0] addr_csr         = 8'h60;

    localparam int         last_reg_valid_bit = 8;
    localparam int         ctrl_clear_bit     = 0;
    localparam int         ctrl_snap_bit      = 1;
    localparam logic [1:0] axil_resp_okay     = 2'b00;

    typedef struct packed {
        logic                  update_pc_en;
        logic [xlen-1:0]       update_pc;
        logic                  mprf_wr_en;
        logic [reg_addr_w-1:0] mprf_wr_addr;
        logic [xlen-1:0]       mprf_wr_data;
        logic                  mstatus_mie_up;
        sort_sel_e             instr_sort;
    } retire_s;

    typedef struct packed {
        logic            mstatus_mie;
        logic            mstatus_mpie;
        logic [xlen-7:0] mtvec_base;
        logic            mtvec_mode;
        logic            mie_meie;
        logic            mie_mtie;
        logic            mie_msie;
        logic            mip_meip;
        logic            mip_mtip;
        logic            mip_msip;
        logic [xlen-2:0] mepc;     // Bit 0 always zero with RVC
        logic            mcause_i;
        logic [3:0]      mcause_ec;
        logic [xlen-1:0] mtval;
    } csr_raw_s;

    typedef struct packed {
        logic [xlen-1:0] mstatus;
        logic [xlen-1:0] mtvec;
        logic [xlen-1:0] mie;
        logic [xlen-1:0] mip;
        logic [xlen-1:0] mepc;
        logic [xlen-1:0] mcause;
        logic [xlen-1:0] mtval;
    } csr_words_s;

    typedef struct packed {
        logic [xlen-1:0]       last_pc;
        logic                  reg_valid;
        logic [reg_addr_w-1:0] reg_idx;
        logic [xlen-1:0]       reg_data;
    } last_write_s;

    typedef struct packed {
        logic                   awvalid;
        logic [axil_addr_w-1:0] awaddr;
        logic                   wvalid;
        logic [xlen-1:0]        wdata;
        logic [xlen/8-1:0]      wstrb;
        logic                   bready;
        logic                   arvalid;
        logic [axil_addr_w-1:0] araddr;
        logic                   rready;
    } axil_req_s;

    typedef struct packed {
        logic            awready;
        logic            wready;
        logic            bvalid;
        logic [1:0]      bresp;
        logic            arready;
        logic            rvalid;
        logic [xlen-1:0] rdata;
        logic [1:0]      rresp;
    } axil_rsp_s;

endpackage

/* verilog/sort_counter.sv */
//----------------------------------------------------------
// Class counter
// Saturating live count with clear and a snapshot copy
//----------------------------------------------------------
`timescale 1ns/1ps

module sort_counter (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          hit,
    input  logic                          clear,
    input  logic                          snap,
    output logic [trace_pkg::count_w-1:0] snap_count
);
    import trace_pkg::*;

    logic [count_w-1:0] live_count;

    // Live count, sticks at all ones
    always_ff @(posedge clk) begin
        if (!rst_n || clear) begin
            live_count <= '0;
        end else if (hit && (live_count != '1)) begin
            live_count <= live_count + 1'b1;
        end
    end

    // Snapshot seen by the bus, all counters copied on one pulse
    always_ff @(posedge clk) begin
        if (!rst_n || clear) begin
            snap_count <= '0;
        end else if (snap) begin
            snap_count <= live_count;
        end
    end

endmodule

/* verilog/retire_classifier.sv */
//----------------------------------------------------------
// Retirement classifier
// Turns retire events into one-hot class hits and keeps the
// latest PC update and nonzero register write
//----------------------------------------------------------
`timescale 1ns/1ps

module retire_classifier (
    input  logic                                clk,
    input  logic                                rst_n,
    input  trace_pkg::retire_s                  retire,
    output logic [trace_pkg::num_classes-1:0]   class_hit,
    output trace_pkg::last_write_s              last_write
);
    import trace_pkg::*;

    logic                   retire_evt;
    logic                   reg_wr;
    logic [num_classes-1:0] class_d;

    logic [xlen-1:0]        last_pc_q;
    logic                   reg_valid_q;
    logic [reg_addr_w-1:0]  reg_idx_q;
    logic [xlen-1:0]        reg_data_q;

    // Writes during an interrupt-enable update do not retire
    assign retire_evt = retire.update_pc_en |
                        (retire.mprf_wr_en & ~retire.mstatus_mie_up);

    assign reg_wr = retire.mprf_wr_en && (retire.mprf_wr_addr != '0);  // x0 ignored

    always_comb begin
        class_d = '0;
        if (retire.instr_sort <= rvc_other) begin
            class_d[retire.instr_sort] = 1'b1;
        end else begin
            class_d[class_other] = 1'b1;  // Undefined sort codes
        end
    end

    // One hit per cycle, counters step on the following edge
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            class_hit <= '0;
        end else if (retire_evt) begin
            class_hit <= class_d;
        end else begin
            class_hit <= '0;
        end
    end

    //------------------------------------------------------
    // Difference trace
    //------------------------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            reg_valid_q <= 1'b0;
            reg_idx_q   <= '0;
        end else if (reg_wr) begin
            reg_valid_q <= 1'b1;
            reg_idx_q   <= retire.mprf_wr_addr;
        end
    end

    always_ff @(posedge clk) begin
        if (retire.update_pc_en) begin
            last_pc_q <= retire.update_pc;
        end
        if (reg_wr) begin
            reg_data_q <= retire.mprf_wr_data;
        end
    end

    assign last_write = '{
        last_pc:   last_pc_q,
        reg_valid: reg_valid_q,
        reg_idx:   reg_idx_q,
        reg_data:  reg_data_q
    };

endmodule

/* verilog/csr_trace_packer.sv */
//----------------------------------------------------------
// CSR trace packer
// Builds full CSR words from raw fields, counts change cycles
//----------------------------------------------------------
`timescale 1ns/1ps

module csr_trace_packer (
    input  logic                          clk,
    input  logic                          rst_n,
    input  trace_pkg::csr_raw_s           csr_raw,
    output trace_pkg::csr_words_s         csr_words,
    output logic [trace_pkg::count_w-1:0] csr_changes
);
    import trace_pkg::*;

    csr_words_s words_d;
    logic       primed;  // Set once csr_words holds a real sample

    //------------------------------------------------------
    // Word packing
    //------------------------------------------------------
    always_comb begin
        words_d = '0;

        words_d.mstatus[mstatus_mie_off]              = csr_raw.mstatus_mie;
        words_d.mstatus[mstatus_mpie_off]             = csr_raw.mstatus_mpie;
        words_d.mstatus[mstatus_mpp_off +: 2]         = mstatus_mpp_val;

        words_d.mtvec = {csr_raw.mtvec_base, 4'd0, 1'b0, csr_raw.mtvec_mode};

        words_d.mie[mie_msie_off] = csr_raw.mie_msie;
        words_d.mie[mie_mtie_off] = csr_raw.mie_mtie;
        words_d.mie[mie_meie_off] = csr_raw.mie_meie;
        words_d.mip[mie_msie_off] = csr_raw.mip_msip;
        words_d.mip[mie_mtie_off] = csr_raw.mip_mtip;
        words_d.mip[mie_meie_off] = csr_raw.mip_meip;

        words_d.mepc = {csr_raw.mepc, 1'b0};

        words_d.mcause[xlen-1] = csr_raw.mcause_i;  // Interrupt flag
        words_d.mcause[3:0]    = csr_raw.mcause_ec;

        words_d.mtval = csr_raw.mtval;
    end

    always_ff @(posedge clk) begin
        csr_words <= words_d;
    end

    // Change cycles against last registered set
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            primed      <= 1'b0;
            csr_changes <= '0;
        end else begin
            primed <= 1'b1;
            if (primed && (words_d != csr_words)) begin
                csr_changes <= csr_changes + 1'b1;
            end
        end
    end

endmodule

/* verilog/trace_axil_regs.sv */
//----------------------------------------------------------
// Trace monitor register slave
// AXI4-Lite handshake, control pulses and read multiplexer
//----------------------------------------------------------
`timescale 1ns/1ps

module trace_axil_regs (
    input  logic                                                    clk,
    input  logic                                                    rst_n,
    input  trace_pkg::axil_req_s                                    axil_req,
    output trace_pkg::axil_rsp_s                                    axil_rsp,
    input  logic [trace_pkg::num_classes-1:0][trace_pkg::count_w-1:0] snap_counts,
    input  trace_pkg::last_write_s                                  last_write,
    input  trace_pkg::csr_words_s                                   csr_words,
    input  logic [trace_pkg::count_w-1:0]                           csr_changes,
    output logic                                                    clear,
    output logic                                                    snap
);
    import trace_pkg::*;

    logic                                 bvalid_q;
    logic                                 rvalid_q;
    logic [xlen-1:0]                      rdata_q;
    logic                                 wr_accept;
    logic                                 rd_accept;
    logic [xlen-1:0]                      rd_word;
    logic [axil_addr_w-1:0]               cnt_off;
    logic [axil_addr_w-1:0]               csr_off;
    logic [num_csr_words-1:0][xlen-1:0]   csr_vec;

    assign wr_accept = axil_req.awvalid & axil_req.wvalid & ~bvalid_q;
    assign rd_accept = axil_req.arvalid & ~rvalid_q;

    //------------------------------------------------------
    // Response channels
    //------------------------------------------------------
    // Address and data only taken together, so no lone AW or W handshake
    assign axil_rsp.awready = ~bvalid_q & ~(axil_req.awvalid ^ axil_req.wvalid);
    assign axil_rsp.wready  = ~bvalid_q & ~(axil_req.awvalid ^ axil_req.wvalid);
    assign axil_rsp.bvalid  = bvalid_q;
    assign axil_rsp.bresp   = axil_resp_okay;
    assign axil_rsp.arready = ~rvalid_q;
    assign axil_rsp.rvalid  = rvalid_q;
    assign axil_rsp.rdata   = rdata_q;
    assign axil_rsp.rresp   = axil_resp_okay;

    // Write path, wstrb not used
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            bvalid_q <= 1'b0;
            clear    <= 1'b0;
            snap     <= 1'b0;
        end else begin
            clear <= 1'b0;  // Single-cycle pulses
            snap  <= 1'b0;
            if (wr_accept) begin
                bvalid_q <= 1'b1;
                if (axil_req.awaddr == addr_ctrl) begin
                    clear <= axil_req.wdata[ctrl_clear_bit];
                    snap  <= axil_req.wdata[ctrl_snap_bit];
                end
            end else if (axil_req.bready) begin
                bvalid_q <= 1'b0;
            end
        end
    end

    // Read path
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rvalid_q <= 1'b0;
        end else if (rd_accept) begin
            rvalid_q <= 1'b1;
        end else if (axil_req.rready) begin
            rvalid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_accept) begin
            rdata_q <= rd_word;  // Held while rready is low
        end
    end

    //------------------------------------------------------
    // Read multiplexer
    //------------------------------------------------------
    always_comb begin
        csr_vec = csr_words;  // mstatus sits in the top word
        cnt_off = axil_req.araddr - addr_counts;
        csr_off = axil_req.araddr - addr_csr;
        rd_word = '0;

        case (axil_req.araddr)
            addr_csr_changes: rd_word = csr_changes;
            addr_last_pc:     rd_word = last_write.last_pc;
            addr_last_reg: begin
                rd_word[reg_addr_w-1:0]     = last_write.reg_idx;
                rd_word[last_reg_valid_bit] = last_write.reg_valid;
            end
            addr_last_data:   rd_word = last_write.reg_data;
            default: begin
                // Offsets below a window base wrap to large values
                if (cnt_off < axil_addr_w'(4 * num_classes)) begin
                    rd_word = snap_counts[cnt_off[axil_addr_w-1:2]];
                end else if (csr_off < axil_addr_w'(4 * num_csr_words)) begin
                    rd_word = csr_vec[num_csr_words - 1 - csr_off[axil_addr_w-1:2]];
                end
            end
        endcase
    end

endmodule

/* verilog/trace_monitor_top.sv */
//----------------------------------------------------------
// Retirement trace monitor, top level
// Class counters, difference trace and CSR trace on AXI4-Lite
//----------------------------------------------------------
`timescale 1ns/1ps

module trace_monitor_top (
    input  logic                 clk,
    input  logic                 rst_n,
    input  trace_pkg::retire_s   retire,
    input  trace_pkg::csr_raw_s  csr_raw,
    input  trace_pkg::axil_req_s axil_req,
    output trace_pkg::axil_rsp_s axil_rsp
);
    import trace_pkg::*;

    logic [num_classes-1:0]              class_hit;
    last_write_s                         last_write;
    csr_words_s                          csr_words;
    logic [count_w-1:0]                  csr_changes;
    logic                                clear;
    logic                                snap;
    logic [num_classes-1:0][count_w-1:0] snap_counts;

    retire_classifier u_classifier (
        .clk        (clk),
        .rst_n      (rst_n),
        .retire     (retire),
        .class_hit  (class_hit),
        .last_write (last_write)
    );

    //------------------------------------------------------
    // One counter per instruction class
    //------------------------------------------------------
    for (genvar i = 0; i < num_classes; i++) begin : g_counter
        sort_counter u_counter (
            .clk        (clk),
            .rst_n      (rst_n),
            .hit        (class_hit[i]),
            .clear      (clear),
            .snap       (snap),
            .snap_count (snap_counts[i])
        );
    end

    csr_trace_packer u_csr_packer (
        .clk         (clk),
        .rst_n       (rst_n),
        .csr_raw     (csr_raw),
        .csr_words   (csr_words),
        .csr_changes (csr_changes)
    );

    trace_axil_regs u_regs (
        .clk         (clk),
        .rst_n       (rst_n),
        .axil_req    (axil_req),
        .axil_rsp    (axil_rsp),
        .snap_counts (snap_counts),
        .last_write  (last_write),
        .csr_words   (csr_words),
        .csr_changes (csr_changes),
        .clear       (clear),
        .snap        (snap)
    );

endmodule

/* test/trace_monitor_checks.svh */
//----------------------------------------------------------
// Testbench bus tasks and typed compares
// AXI4-Lite single transfers with bounded handshake waits
//----------------------------------------------------------

task automatic timeout_fail(input string what);
    errors++;
    $display("timeout: no %s within %0d cycles at %0t", what, axil_timeout, $time);
    abort_req = 1'b1;
endtask

task automatic axil_write(input logic [axil_addr_w-1:0] addr, input logic [xlen-1:0] data);
    int cycles;
    @(negedge clk);
    check_flag("awready when idle", axil_rsp.awready, 1'b1);
    check_flag("wready when idle", axil_rsp.wready, 1'b1);
    axil_req.awaddr  = addr;
    axil_req.wdata   = data;
    axil_req.wstrb   = '1;
    axil_req.awvalid = 1'b1;
    axil_req.wvalid  = 1'b1;
    cycles = 0;
    while (!axil_rsp.bvalid && cycles < axil_timeout) begin
        @(negedge clk);
        cycles++;
    end
    if (axil_rsp.bvalid) begin
        check_flag("awready with response pending", axil_rsp.awready, 1'b0);
        check_flag("wready with response pending", axil_rsp.wready, 1'b0);
        check_resp("bresp", axil_rsp.bresp, 2'b00);  // OKAY
    end else begin
        timeout_fail("write response");
    end
    axil_req.awvalid = 1'b0;
    axil_req.wvalid  = 1'b0;
    cycles = 0;
    while (axil_rsp.bvalid && cycles < axil_timeout) begin  // bready stays high
        @(negedge clk);
        cycles++;
    end
    if (axil_rsp.bvalid) begin
        timeout_fail("write response release");
    end
endtask

task automatic axil_read(input logic [axil_addr_w-1:0] addr, output logic [xlen-1:0] data);
    int cycles;
    @(negedge clk);
    axil_req.araddr  = addr;
    axil_req.arvalid = 1'b1;
    axil_req.rready  = 1'b1;
    cycles = 0;
    while (!axil_rsp.rvalid && cycles < axil_timeout) begin
        @(negedge clk);
        cycles++;
    end
    data = axil_rsp.rdata;
    axil_req.arvalid = 1'b0;
    if (axil_rsp.rvalid) begin
        check_resp("rresp", axil_rsp.rresp, 2'b00);
    end else begin
        timeout_fail("read data");
    end
    cycles = 0;
    while (axil_rsp.rvalid && cycles < axil_timeout) begin
        @(negedge clk);
        cycles++;
    end
    if (axil_rsp.rvalid) begin
        timeout_fail("read data release");
    end
endtask

//----------------------------------------------------------
// Typed compares
//----------------------------------------------------------
task automatic check_count(input string name, input logic [count_w-1:0] got,
                           input logic [count_w-1:0] exp);
    if (got !== exp) begin
        errors++;
        $display("mismatch at %0t: %s got %0d expected %0d", $time, name, got, exp);
    end
endtask

task automatic check_word(input string name, input logic [xlen-1:0] got,
                          input logic [xlen-1:0] exp);
    if (got !== exp) begin
        errors++;
        $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
    end
endtask

task automatic check_reg(input string name, input last_write_s got, input last_write_s exp);
    if (got !== exp) begin
        errors++;
        $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
    end
endtask

task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
        errors++;
        $display("mismatch at %0t: %s got %b expected %b", $time, name, got, exp);
    end
endtask

task automatic check_resp(input string name, input logic [1:0] got, input logic [1:0] exp);
    if (got !== exp) begin
        errors++;
        $display("mismatch at %0t: %s got %b expected %b", $time, name, got, exp);
    end
endtask

/* test/trace_monitor_tb.sv */
//----------------------------------------------------------
// Trace monitor testbench
// Random retire and CSR traffic with results read over AXI4-Lite
//----------------------------------------------------------
`timescale 1ns/1ps

module trace_monitor_tb;
    import trace_pkg::*;

    localparam int axil_timeout = 200;  // Cycles per handshake wait

    logic               clk = 1'b0;
    logic               rst_n;
    retire_s            retire;
    csr_raw_s           csr_raw;
    axil_req_s          axil_req;
    axil_rsp_s          axil_rsp;

    integer             seed;
    int                 errors;
    int                 tests;
    logic               abort_req;
    logic [count_w-1:0] model_count [num_classes];
    logic [count_w-1:0] count_base  [num_classes];  // Model counts at the last clear
    logic [count_w-1:0] model_csr_changes;
    last_write_s        exp_last;
    logic [xlen-1:0]    rd_a;
    logic [xlen-1:0]    rd_b;
    int                 errs_before;

    trace_monitor_top uut (
        .clk      (clk),
        .rst_n    (rst_n),
        .retire   (retire),
        .csr_raw  (csr_raw),
        .axil_req (axil_req),
        .axil_rsp (axil_rsp)
    );

    always #4 clk = ~clk;

    `include "trace_monitor_checks.svh"

    //------------------------------------------------------
    // Reference model
    //------------------------------------------------------
    function automatic int expected_class(input sort_sel_e sel);
        if (sel > rvc_other) begin
            return num_classes - 1;  // Undefined codes
        end
        return int'(sel);
    endfunction

    function automatic logic retire_event(input retire_s r);
        return r.update_pc_en || (r.mprf_wr_en && !r.mstatus_mie_up);
    endfunction

    function automatic logic [xlen-1:0] expected_csr_word(input csr_raw_s raw, input int idx);
        logic [xlen-1:0] w;
        w = '0;
        case (idx)
            0: begin
                w[3]     = raw.mstatus_mie;
                w[7]     = raw.mstatus_mpie;
                w[12:11] = 2'd3;  // MPP set to machine mode
            end
            1: begin
                w[xlen-1:6] = raw.mtvec_base;
                w[0]        = raw.mtvec_mode;
            end
            2: w = {20'd0, raw.mie_meie, 3'd0, raw.mie_mtie, 3'd0, raw.mie_msie, 3'd0};
            3: w = {20'd0, raw.mip_meip, 3'd0, raw.mip_mtip, 3'd0, raw.mip_msip, 3'd0};
            4: w = {raw.mepc, 1'b0};
            5: begin
                w[xlen-1] = raw.mcause_i;
                w[3:0]    = raw.mcause_ec;
            end
            default: w = raw.mtval;
        endcase
        return w;
    endfunction

    // Counts events on the same edge the DUT samples them
    always @(posedge clk) begin : model_counts
        int cls;
        cls = expected_class(retire.instr_sort);
        if (!rst_n) begin
            for (int i = 0; i < num_classes; i++) begin
                model_count[i] <= '0;
            end
        end else if (retire_event(retire)) begin
            model_count[cls] <= model_count[cls] + 32'd1;
        end
    end

    initial begin
        wait (abort_req);
        $display("TB FAILED");
        $finish;
    end

    //------------------------------------------------------
    // Stimulus and test tasks
    //------------------------------------------------------
    task automatic drive_random_events(input int n, input logic x0_only);
        logic [31:0] r;
        for (int i = 0; i < n; i++) begin
            r = $random(seed);
            @(negedge clk);
            retire.update_pc_en   = r[0] & ~x0_only;
            retire.mprf_wr_en     = r[1] | x0_only;
            retire.mstatus_mie_up = (r[4:2] == 3'd0);  // Write-only cycles not counted
            retire.mprf_wr_addr   = x0_only ? 5'd0 : r[9:5];
            retire.instr_sort     = sort_sel_e'(r[13:10]);
            retire.update_pc      = $random(seed) & 32'hffff_fffe;
            retire.mprf_wr_data   = $random(seed);
            if (retire.update_pc_en) begin
                exp_last.last_pc = retire.update_pc;
            end
            if (retire.mprf_wr_en && (retire.mprf_wr_addr != 5'd0)) begin
                exp_last.reg_valid = 1'b1;
                exp_last.reg_idx   = retire.mprf_wr_addr;
                exp_last.reg_data  = retire.mprf_wr_data;
            end
        end
        @(negedge clk);
        retire = '0;
        repeat (3) @(negedge clk);  // Last hit reaches the counters
    endtask

    task automatic drive_csr_sets(input int n);
        logic [127:0] wide;
        logic [31:0]  r;
        csr_raw_s     next;
        for (int i = 0; i < n; i++) begin
            wide = {$random(seed), $random(seed), $random(seed), $random(seed)};
            r    = $random(seed);
            if (r[1:0] == 2'd0) begin
                next = csr_raw;  // Previous set held again
            end else begin
                next = wide[$bits(csr_raw_s)-1:0];
            end
            @(negedge clk);
            if (next != csr_raw) begin
                model_csr_changes = model_csr_changes + 32'd1;
            end
            csr_raw = next;
            repeat (int'(r[3:2])) @(negedge clk);
        end
        repeat (2) @(negedge clk);
    endtask

    task automatic check_snapshot_counts();
        logic [xlen-1:0] rd;
        axil_write(addr_ctrl, 32'h2);  // Snap
        for (int i = 0; i < num_classes; i++) begin
            axil_read(axil_addr_w'(addr_counts + 4 * i), rd);
            check_count($sformatf("count[%0d]", i), rd, model_count[i] - count_base[i]);
        end
    endtask

    task automatic check_last_write();
        logic [xlen-1:0] reg_word;
        last_write_s     got;
        axil_read(addr_last_pc, got.last_pc);
        axil_read(addr_last_reg, reg_word);
        axil_read(addr_last_data, got.reg_data);
        got.reg_valid = reg_word[8];
        got.reg_idx   = reg_word[reg_addr_w-1:0];
        check_reg("last_write", got, exp_last);
    endtask

    task automatic check_csr_words();
        logic [xlen-1:0] rd;
        axil_read(addr_csr_changes, rd);
        check_count("csr_changes", rd, model_csr_changes);
        for (int i = 0; i < 7; i++) begin
            axil_read(axil_addr_w'(addr_csr + 4 * i), rd);
            check_word($sformatf("csr word %0d", i), rd, expected_csr_word(csr_raw, i));
        end
    endtask

    // First read held by rready low while a second one waits behind it
    task automatic read_held(input logic [axil_addr_w-1:0] addr_a,
                             input logic [axil_addr_w-1:0] addr_b,
                             input int hold, output logic [xlen-1:0] data_a,
                             output logic [xlen-1:0] data_b);
        int cycles;
        @(negedge clk);
        axil_req.araddr  = addr_a;
        axil_req.arvalid = 1'b1;
        axil_req.rready  = 1'b0;
        cycles = 0;
        while (!axil_rsp.rvalid && cycles < axil_timeout) begin
            @(negedge clk);
            cycles++;
        end
        if (!axil_rsp.rvalid) begin
            timeout_fail("held read data");
        end
        data_a = axil_rsp.rdata;
        axil_req.araddr = addr_b;
        repeat (hold) begin
            @(negedge clk);
            if (!axil_rsp.rvalid) begin
                errors++;
                $display("rvalid dropped at %0t while rready was low", $time);
            end
            if (axil_rsp.arready) begin
                errors++;
                $display("second read accepted at %0t while a response was pending", $time);
            end
            check_word("rdata while held", axil_rsp.rdata, data_a);
        end
        axil_req.rready = 1'b1;
        @(negedge clk);
        if (axil_rsp.rvalid) begin
            errors++;
            $display("rvalid still high at %0t after rready", $time);
        end
        cycles = 0;
        while (!axil_rsp.rvalid && cycles < axil_timeout) begin
            @(negedge clk);
            cycles++;
        end
        if (!axil_rsp.rvalid) begin
            timeout_fail("second read data");
        end
        data_b = axil_rsp.rdata;
        axil_req.arvalid = 1'b0;
        @(negedge clk);
    endtask

    task automatic report_test(input string name, input int errs_at_start);
        tests++;
        if (errors == errs_at_start) begin
            $display("test %0d %s: ok", tests, name);
        end else begin
            $display("test %0d %s: %0d errors", tests, name, errors - errs_at_start);
        end
    endtask

    //------------------------------------------------------
    // Test sequence
    //------------------------------------------------------
    initial begin
        seed              = 54;
        errors            = 0;
        tests             = 0;
        abort_req         = 1'b0;
        rst_n             = 1'b0;
        retire            = '0;
        csr_raw           = '0;
        axil_req          = '0;
        axil_req.bready   = 1'b1;
        axil_req.rready   = 1'b1;
        model_csr_changes = '0;
        exp_last          = '0;
        for (int i = 0; i < num_classes; i++) begin
            count_base[i] = '0;
        end
        repeat (10) @(negedge clk);
        rst_n = 1'b1;

        errs_before = errors;
        check_flag("bvalid after reset", axil_rsp.bvalid, 1'b0);
        check_flag("rvalid after reset", axil_rsp.rvalid, 1'b0);
        check_flag("awready after reset", axil_rsp.awready, 1'b1);
        check_flag("wready after reset", axil_rsp.wready, 1'b1);
        check_flag("arready after reset", axil_rsp.arready, 1'b1);
        for (int i = 0; i < num_classes; i++) begin
            axil_read(axil_addr_w'(addr_counts + 4 * i), rd_a);
            check_count($sformatf("count[%0d] after reset", i), rd_a, '0);
        end
        axil_read(addr_csr_changes, rd_a);
        check_count("csr_changes after reset", rd_a, '0);
        axil_read(addr_last_reg, rd_a);
        check_word("last_reg after reset", rd_a, '0);
        report_test("reset values", errs_before);

        errs_before = errors;
        drive_random_events(200, 1'b0);
        check_snapshot_counts();
        report_test("class counts", errs_before);

        errs_before = errors;
        check_last_write();
        drive_random_events(8, 1'b1);  // x0 writes only
        check_last_write();
        report_test("difference trace", errs_before);

        errs_before = errors;
        drive_csr_sets(40);
        check_csr_words();
        report_test("csr trace", errs_before);

        errs_before = errors;
        for (int i = 0; i < num_classes; i++) begin
            count_base[i] = model_count[i];
        end
        axil_write(addr_ctrl, 32'h1);  // Clear
        check_snapshot_counts();
        drive_random_events(60, 1'b0);
        check_snapshot_counts();
        report_test("clear and recount", errs_before);

        errs_before = errors;
        read_held(addr_counts, addr_csr_changes, 5, rd_a, rd_b);
        check_count("count[0] held read", rd_a, model_count[0] - count_base[0]);
        check_count("csr_changes queued read", rd_b, model_csr_changes);
        report_test("read back-pressure", errs_before);

        $display("tests run %0d, errors %0d", tests, errors);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

/* vlog.f */
+incdir+test
verilog/trace_pkg.sv
verilog/sort_counter.sv
verilog/retire_classifier.sv
verilog/csr_trace_packer.sv
verilog/trace_axil_regs.sv
verilog/trace_monitor_top.sv
test/trace_monitor_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the trace monitor testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing -f vlog.f --top-module trace_monitor_tb \
        -o trace_monitor_sim; then
    echo "Verilator build failed"
    exit 1
fi

if ! sim_out=$(./obj_dir/trace_monitor_sim); then
    echo "$sim_out"
    echo "Simulation exited with an error"
    exit 1
fi

echo "$sim_out"
if grep -qx "TB PASSED" <<< "$sim_out"; then
    exit 0
fi
echo "Pass message not found in simulation output"
exit 1
